/* data_cache.f */
rtl/cache_geometry_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/cache_control.sv
rtl/cache_store.sv
rtl/cache_lane_align.sv
rtl/data_cache.sv
verification/data_cache_sva.sv
verification/data_cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := data_cache_tb
FILELIST  := data_cache.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the result"
	@echo "  clean  remove build output and the log"

$(OBJ_DIR)/$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)

test: $(OBJ_DIR)/$(TOP)
	-./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/data_cache_tb.sv */
module data_cache_tb;

  localparam int TIMEOUT = 200;
  localparam int MEM_WORDS = 2048;

  logic clock;
  logic reset;
  logic req, wr_en, rd_signed, done;
  logic [cache_geometry_pkg::LANES-1:0] sel;
  logic [cache_geometry_pkg::ADDR_W-1:0] addr, mem_addr;
  logic [cache_geometry_pkg::DATA_W-1:0] wr_data, rd_data;
  logic mem_rd_en, mem_wr_en, mem_ready;
  logic [cache_geometry_pkg::BLOCK_W-1:0] mem_wr_data, mem_rd_data;

  // Backing memory and the expected image of it
  logic [31:0] mem_words [MEM_WORDS];
  logic [31:0] shadow [MEM_WORDS];

  int errors = 0;
  int read_errors = 0;
  int wb_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int rd_count = 0;
  int wb_count = 0;
  logic [31:0] last_wb_addr = '0;
  bit hung = 1'b0;
  bit pend_read = 1'b0;
  logic [31:0] pend_exp = '0;
  logic [31:0] pend_addr = '0;

  data_cache DUT (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9e3779b1) ^ 32'h5a17c3e9;
  endfunction

  // Load result: shift to lane 0, then zero or sign extend by size
  function automatic logic [31:0] ref_load(input logic [31:0] word, input logic [31:0] a,
                                           input logic [3:0] s, input logic sg);
    logic [31:0] v;
    int o;
    o = {30'b0, a[1:0]};
    v = word >> (8 * o);
    case (s)
      4'b0001: v = sg ? {{24{v[7]}}, v[7:0]} : {24'h0, v[7:0]};
      4'b0011: v = sg ? {{16{v[15]}}, v[15:0]} : {16'h0, v[15:0]};
      default: v = v;
    endcase
    return v;
  endfunction

  function automatic logic [31:0] merge_store(input logic [31:0] word, input logic [31:0] a,
                                              input logic [3:0] s, input logic [31:0] d);
    logic [31:0] w;
    int o;
    w = word;
    o = {30'b0, a[1:0]};
    for (int i = 0; i < 4; i++) begin
      if (s[i] && (i + o) < 4) begin
        w[8*(i+o) +: 8] = d[8*i +: 8];
      end
    end
    return w;
  endfunction

  function automatic int total_errors();
    return errors + read_errors + wb_errors;
  endfunction

  // Memory answers each strobe after 1 to 4 cycles
  initial begin : memory_model
    int lat;
    bit is_wr;
    mem_ready = 1'b0;
    mem_rd_data = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_words[11'(i)] = fill_word(i << 2);
    end
    forever begin
      @(negedge clock);
      mem_ready = 1'b0;
      if (!reset && (mem_rd_en || mem_wr_en)) begin
        is_wr = mem_wr_en;
        if (is_wr) begin
          wb_count++;
          last_wb_addr = mem_addr;
          for (int i = 0; i < 4; i++) begin
            mem_words[{mem_addr[12:4], 2'(i)}] = mem_wr_data[32*i +: 32];
            assert (mem_wr_data[32*i +: 32] === shadow[{mem_addr[12:4], 2'(i)}]) else begin
              $display("ERROR at %0t: write-back of %h word %0d is %h, expected %h", $time,
                       mem_addr, i, mem_wr_data[32*i +: 32], shadow[{mem_addr[12:4], 2'(i)}]);
              wb_errors++;
            end
          end
        end
        lat = $urandom_range(4, 1);
        repeat (lat) @(negedge clock);
        if (!is_wr) begin
          rd_count++;
          for (int i = 0; i < 4; i++) begin
            mem_rd_data[32*i +: 32] = mem_words[{mem_addr[12:4], 2'(i)}];
          end
        end
        mem_ready = 1'b1;
      end
    end
  end

  // Compares every read completion with the expected value
  always @(negedge clock) begin
    if (!reset && done && pend_read) begin
      assert (rd_data === pend_exp) else begin
        $display("ERROR at %0t: read of %h returned %h, expected %h", $time, pend_addr,
                 rd_data, pend_exp);
        read_errors++;
      end
    end
  end

  task automatic check(input bit ok, input string what);
    if (!hung) begin
      assert (ok) else begin
        $display("ERROR at %0t: %s", $time, what);
        errors++;
      end
    end
  endtask

  // One request, then wait for done; lat counts cycles after the request edge
  task automatic access(input logic w, input logic [3:0] s, input logic [31:0] a,
                        input logic [31:0] d, input logic sg, output int lat);
    logic [10:0] idx;
    lat = 0;
    if (hung) return;
    idx = a[12:2];
    @(negedge clock);
    pend_read = !w;
    pend_addr = a;
    pend_exp = ref_load(shadow[idx], a, s, sg);
    if (w) begin
      shadow[idx] = merge_store(shadow[idx], a, s, d);
    end
    req = 1'b1;
    wr_en = w;
    sel = s;
    addr = a;
    wr_data = d;
    rd_signed = sg;
    @(negedge clock);
    req = 1'b0;
    lat = 1;
    while (!done && lat < TIMEOUT) begin
      @(negedge clock);
      lat++;
    end
    if (!done) begin
      $display("Timeout: no done within %0d cycles for the request to %h", TIMEOUT, a);
      hung = 1'b1;
      errors++;
    end
  endtask

  task automatic report(input int num, input string name, input int e0);
    tests_run++;
    if (total_errors() == e0) begin
      $display("Test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", num, name, total_errors() - e0);
    end
  endtask

  initial begin
    int lat;
    int e0;
    int n0;
    int k;
    logic [31:0] a;
    logic [3:0] s;
    void'($urandom(32'h3168a13c));
    reset = 1'b1;
    req = 1'b0;
    wr_en = 1'b0;
    sel = '0;
    addr = '0;
    wr_data = '0;
    rd_signed = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[11'(i)] = fill_word(i << 2);
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    e0 = total_errors();
    check(!done && !mem_rd_en && !mem_wr_en, "done or a memory strobe high after reset");
    access(1'b0, 4'b1111, 32'h44, 32'h0, 1'b0, lat);
    check(rd_count == 1, $sformatf("first read caused %0d memory reads", rd_count));
    check(lat > 1, $sformatf("first read completed as a hit after %0d cycles", lat));
    report(1, "reset and first read", e0);

    e0 = total_errors();
    access(1'b1, 4'b1111, 32'h60, 32'h11223344, 1'b0, lat);
    access(1'b1, 4'b0001, 32'h61, 32'h000000aa, 1'b0, lat);
    check(lat == 1, $sformatf("byte write hit took %0d cycles", lat));
    access(1'b1, 4'b0011, 32'h62, 32'h0000beef, 1'b0, lat);
    access(1'b0, 4'b1111, 32'h60, 32'h0, 1'b0, lat);
    access(1'b0, 4'b1111, 32'h60, 32'h0, 1'b0, lat);
    check(lat == 1, $sformatf("repeated read hit took %0d cycles", lat));
    report(2, "write merge and hit latency", e0);

    e0 = total_errors();
    access(1'b1, 4'b1111, 32'h80, 32'h80ff7f01, 1'b0, lat);
    for (int off = 0; off < 4; off++) begin
      access(1'b0, 4'b0001, 32'h80 + off, 32'h0, 1'b0, lat);
      access(1'b0, 4'b0001, 32'h80 + off, 32'h0, 1'b1, lat);
      if (off % 2 == 0) begin
        access(1'b0, 4'b0011, 32'h80 + off, 32'h0, 1'b0, lat);
        access(1'b0, 4'b0011, 32'h80 + off, 32'h0, 1'b1, lat);
      end
    end
    report(3, "signed and unsigned loads", e0);

    // Set 31 is untouched so far, so the third block evicts the first
    e0 = total_errors();
    n0 = wb_count;
    access(1'b1, 4'b1111, 32'h1f0, 32'ha1a1a1a1, 1'b0, lat);
    access(1'b1, 4'b1111, 32'h3f4, 32'hb2b2b2b2, 1'b0, lat);
    access(1'b1, 4'b1111, 32'h5f8, 32'hc3c3c3c3, 1'b0, lat);
    check(wb_count == n0 + 1 && last_wb_addr == 32'h1f0,
          $sformatf("%0d write-backs, last to %h", wb_count - n0, last_wb_addr));
    access(1'b0, 4'b1111, 32'h1f0, 32'h0, 1'b0, lat);
    access(1'b0, 4'b1111, 32'h3f4, 32'h0, 1'b0, lat);
    access(1'b0, 4'b1111, 32'h5f8, 32'h0, 1'b0, lat);
    report(4, "dirty eviction", e0);

    e0 = total_errors();
    for (int i = 0; i < 300; i++) begin
      a = ($urandom_range(3, 0) << 9) | ($urandom_range(3, 0) << 4) |
          ($urandom_range(3, 0) << 2);
      k = $urandom_range(2, 0);
      s = (k == 0) ? 4'b0001 : (k == 1) ? 4'b0011 : 4'b1111;
      if (k == 0) begin
        a = a + $urandom_range(3, 0);
      end else if (k == 1) begin
        a = a + 2 * $urandom_range(1, 0);
      end
      access(1'($urandom_range(1, 0)), s, a, $urandom, 1'($urandom_range(1, 0)), lat);
    end
    report(5, "random reads and writes", e0);

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (total_errors() == 0 && !hung) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verification/data_cache_sva.sv */
module data_cache_sva (
  input logic                          clock,
  input logic                          reset,
  input cache_ctrl_pkg::cache_state_t  state,
  input logic                          mem_rd_en,
  input logic                          mem_wr_en,
  input logic                          done
);

  // Memory strobes never overlap
  assert property (@(posedge clock) disable iff (reset) !(mem_rd_en && mem_wr_en))
    else $error("mem_rd_en and mem_wr_en high in the same cycle");

  // Single-cycle pulses
  assert property (@(posedge clock) disable iff (reset) mem_rd_en |=> !mem_rd_en)
    else $error("mem_rd_en high for more than one cycle");
  assert property (@(posedge clock) disable iff (reset) mem_wr_en |=> !mem_wr_en)
    else $error("mem_wr_en high for more than one cycle");
  assert property (@(posedge clock) disable iff (reset) done |=> !done)
    else $error("done high for more than one cycle");

  assert property (@(posedge clock) disable iff (reset) done |-> state != cache_ctrl_pkg::ST_IDLE)
    else $error("done raised while idle");
  assert property (@(posedge clock) disable iff (reset)
                   done |-> state == cache_ctrl_pkg::ST_LOOKUP)
    else $error("done raised outside of lookup");

endmodule

bind cache_control data_cache_sva u_sva (
  .clock(clock), .reset(reset), .state(state), .mem_rd_en(mem_rd_en),
  .mem_wr_en(mem_wr_en), .done(done)
);

/* rtl/data_cache.sv */
module data_cache (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    req,
  input  logic                                    wr_en,
  input  logic [cache_geometry_pkg::LANES-1:0]    sel,
  input  logic [cache_geometry_pkg::ADDR_W-1:0]   addr,
  input  logic [cache_geometry_pkg::DATA_W-1:0]   wr_data,
  input  logic                                    rd_signed,
  output logic [cache_geometry_pkg::DATA_W-1:0]   rd_data,
  output logic                                    done,
  output logic                                    mem_rd_en,
  output logic                                    mem_wr_en,
  output logic [cache_geometry_pkg::ADDR_W-1:0]   mem_addr,
  output logic [cache_geometry_pkg::BLOCK_W-1:0]  mem_wr_data,
  input  logic [cache_geometry_pkg::BLOCK_W-1:0]  mem_rd_data,
  input  logic                                    mem_ready
);

  // Request registers
  logic [cache_geometry_pkg::ADDR_W-1:0]  req_addr;
  logic [cache_geometry_pkg::DATA_W-1:0]  req_wr_data;
  logic [cache_geometry_pkg::LANES-1:0]   req_sel;
  logic                                   req_wr_en;
  logic                                   req_rd_signed;

  logic [cache_geometry_pkg::LANE_W-1:0]   byte_off;
  logic [cache_geometry_pkg::WORDS_W-1:0]  word_sel;
  logic [cache_geometry_pkg::INDEX_W-1:0]  index;
  logic [cache_geometry_pkg::TAG_W-1:0]    tag;

  logic sample;
  logic set_valid;
  logic set_tag;
  logic fill;
  logic store;
  logic next_victim;
  logic wb_select;
  logic hit;
  logic victim_dirty;

  logic [cache_geometry_pkg::TAG_W-1:0]   victim_tag;
  logic [cache_geometry_pkg::DATA_W-1:0]  hit_word;
  logic [cache_geometry_pkg::DATA_W-1:0]  store_data;
  logic [cache_geometry_pkg::LANES-1:0]   store_lanes;

  always_ff @(posedge clock) begin
    if (sample) begin
      req_addr <= addr;
      req_wr_data <= wr_data;
      req_sel <= sel;
      req_wr_en <= wr_en;
      req_rd_signed <= rd_signed;
    end
  end

  assign byte_off = req_addr[cache_geometry_pkg::LANE_W-1:0];
  assign word_sel = req_addr[cache_geometry_pkg::OFFSET_W-1:cache_geometry_pkg::WORD_LSB];
  assign index = req_addr[cache_geometry_pkg::TAG_LSB-1:cache_geometry_pkg::INDEX_LSB];
  assign tag = req_addr[cache_geometry_pkg::ADDR_W-1:cache_geometry_pkg::TAG_LSB];

  // Victim block address during write-back, else the requested block
  assign mem_addr = wb_select ?
    {victim_tag, index, {cache_geometry_pkg::OFFSET_W{1'b0}}} :
    {req_addr[cache_geometry_pkg::ADDR_W-1:cache_geometry_pkg::OFFSET_W],
     {cache_geometry_pkg::OFFSET_W{1'b0}}};

  cache_control u_control (
    .clock(clock), .reset(reset), .req(req), .wr_en(req_wr_en), .hit(hit),
    .victim_dirty(victim_dirty), .mem_ready(mem_ready), .sample(sample),
    .set_valid(set_valid), .set_tag(set_tag), .fill(fill), .store(store),
    .next_victim(next_victim), .wb_select(wb_select), .mem_rd_en(mem_rd_en),
    .mem_wr_en(mem_wr_en), .done(done)
  );

  cache_store u_store (
    .clock(clock), .reset(reset), .index(index), .tag(tag), .word_sel(word_sel),
    .fill(fill), .store(store), .set_tag(set_tag), .set_valid(set_valid),
    .next_victim(next_victim), .mem_rd_data(mem_rd_data), .store_data(store_data),
    .store_lanes(store_lanes), .hit(hit), .victim_dirty(victim_dirty),
    .victim_tag(victim_tag), .victim_block(mem_wr_data), .hit_word(hit_word)
  );

  cache_lane_align u_align (
    .sel(req_sel), .byte_off(byte_off), .rd_signed(req_rd_signed), .wr_data(req_wr_data),
    .hit_word(hit_word), .store_data(store_data), .store_lanes(store_lanes),
    .rd_data(rd_data)
  );

endmodule

/* rtl/cache_lane_align.sv */
module cache_lane_align (
  input  logic [cache_geometry_pkg::LANES-1:0]   sel,
  input  logic [cache_geometry_pkg::LANE_W-1:0]  byte_off,
  input  logic                                   rd_signed,
  input  logic [cache_geometry_pkg::DATA_W-1:0]  wr_data,
  input  logic [cache_geometry_pkg::DATA_W-1:0]  hit_word,
  output logic [cache_geometry_pkg::DATA_W-1:0]  store_data,
  output logic [cache_geometry_pkg::LANES-1:0]   store_lanes,
  output logic [cache_geometry_pkg::DATA_W-1:0]  rd_data
);

  localparam int SHIFT_W = cache_geometry_pkg::LANE_W + $clog2(cache_geometry_pkg::BYTE_W);

  logic [SHIFT_W-1:0]                     bit_shift;
  logic [cache_geometry_pkg::DATA_W-1:0]  shifted_word;
  logic                                   top_bit;
  logic                                   ext_bit;

  // Byte offset in bits
  assign bit_shift = {byte_off, {($clog2(cache_geometry_pkg::BYTE_W)){1'b0}}};

  // Store side, low lanes moved up to the addressed bytes
  assign store_data = wr_data << bit_shift;
  assign store_lanes = sel << byte_off;

  // Load side, addressed bytes brought down to lane 0
  assign shifted_word = hit_word >> bit_shift;

  // Most significant bit of the highest selected lane
  always_comb begin
    top_bit = 1'b0;
    for (int l = 0; l < cache_geometry_pkg::LANES; l++) begin
      if (sel[l]) begin
        top_bit = shifted_word[l*cache_geometry_pkg::BYTE_W + cache_geometry_pkg::BYTE_W - 1];
      end
    end
  end

  assign ext_bit = rd_signed & top_bit;

  always_comb begin
    for (int l = 0; l < cache_geometry_pkg::LANES; l++) begin
      if (sel[l]) begin
        rd_data[l*cache_geometry_pkg::BYTE_W +: cache_geometry_pkg::BYTE_W] =
          shifted_word[l*cache_geometry_pkg::BYTE_W +: cache_geometry_pkg::BYTE_W];
      end else begin
        rd_data[l*cache_geometry_pkg::BYTE_W +: cache_geometry_pkg::BYTE_W] =
          {cache_geometry_pkg::BYTE_W{ext_bit}};
      end
    end
  end

endmodule

/* rtl/cache_store.sv */
module cache_store (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic [cache_geometry_pkg::INDEX_W-1:0]  index,
  input  logic [cache_geometry_pkg::TAG_W-1:0]    tag,
  input  logic [cache_geometry_pkg::WORDS_W-1:0]  word_sel,
  input  logic                                    fill,
  input  logic                                    store,
  input  logic                                    set_tag,
  input  logic                                    set_valid,
  input  logic                                    next_victim,
  input  logic [cache_geometry_pkg::BLOCK_W-1:0]  mem_rd_data,
  input  logic [cache_geometry_pkg::DATA_W-1:0]   store_data,
  input  logic [cache_geometry_pkg::LANES-1:0]    store_lanes,
  output logic                                    hit,
  output logic                                    victim_dirty,
  output logic [cache_geometry_pkg::TAG_W-1:0]    victim_tag,
  output logic [cache_geometry_pkg::BLOCK_W-1:0]  victim_block,
  output logic [cache_geometry_pkg::DATA_W-1:0]   hit_word
);

  logic [cache_geometry_pkg::SETS-1:0][cache_geometry_pkg::WAYS-1:0] valid_bits;
  logic [cache_geometry_pkg::SETS-1:0][cache_geometry_pkg::WAYS-1:0] dirty_bits;

  logic [cache_geometry_pkg::TAG_W-1:0]
    tag_mem [cache_geometry_pkg::SETS][cache_geometry_pkg::WAYS];
  logic [cache_geometry_pkg::BLOCK_W-1:0]
    data_mem [cache_geometry_pkg::SETS][cache_geometry_pkg::WAYS];

  logic [cache_geometry_pkg::WAYS-1:0]    way_match;
  logic [cache_geometry_pkg::WAY_W-1:0]   hit_way;
  logic [cache_geometry_pkg::WAY_W-1:0]   victim_way;
  logic [cache_geometry_pkg::DATA_W-1:0]  merged_word;

  // Tag compare in every way of the set
  always_comb begin
    for (int w = 0; w < cache_geometry_pkg::WAYS; w++) begin
      way_match[w] = valid_bits[index][w] && (tag_mem[index][w] == tag);
    end
  end

  // Lowest matching way wins
  always_comb begin
    hit_way = '0;
    for (int w = cache_geometry_pkg::WAYS - 1; w >= 0; w--) begin
      if (way_match[w]) begin
        hit_way = w[cache_geometry_pkg::WAY_W-1:0];
      end
    end
  end

  assign hit = |way_match;
  assign hit_word = data_mem[index][hit_way][word_sel*cache_geometry_pkg::DATA_W +:
                                             cache_geometry_pkg::DATA_W];

  assign victim_dirty = dirty_bits[index][victim_way];
  assign victim_tag = tag_mem[index][victim_way];
  assign victim_block = data_mem[index][victim_way];

  // Byte merge of the store into the hit word
  always_comb begin
    merged_word = hit_word;
    for (int l = 0; l < cache_geometry_pkg::LANES; l++) begin
      if (store_lanes[l]) begin
        merged_word[l*cache_geometry_pkg::BYTE_W +: cache_geometry_pkg::BYTE_W] =
          store_data[l*cache_geometry_pkg::BYTE_W +: cache_geometry_pkg::BYTE_W];
      end
    end
  end

  // Round-robin victim, advanced once per refill
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      victim_way <= '0;
    end else if (next_victim) begin
      victim_way <= victim_way + 1'b1;
    end
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      valid_bits <= '0;
    end else if (set_valid) begin
      valid_bits[index][victim_way] <= 1'b1;
    end
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      dirty_bits <= '0;
    end else if (fill) begin
      dirty_bits[index][victim_way] <= 1'b0;
    end else if (store) begin
      dirty_bits[index][hit_way] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (set_tag) begin
      tag_mem[index][victim_way] <= tag;
    end
  end

  always_ff @(posedge clock) begin
    if (fill) begin
      data_mem[index][victim_way] <= mem_rd_data;
    end else if (store) begin
      data_mem[index][hit_way][word_sel*cache_geometry_pkg::DATA_W +:
                               cache_geometry_pkg::DATA_W] <= merged_word;
    end
  end

endmodule

/* rtl/cache_control.sv */
module cache_control (
  input  logic clock,
  input  logic reset,
  input  logic req,
  input  logic wr_en,
  input  logic hit,
  input  logic victim_dirty,
  input  logic mem_ready,
  output logic sample,
  output logic set_valid,
  output logic set_tag,
  output logic fill,
  output logic store,
  output logic next_victim,
  output logic wb_select,
  output logic mem_rd_en,
  output logic mem_wr_en,
  output logic done
);

  cache_ctrl_pkg::cache_state_t state;
  cache_ctrl_pkg::cache_state_t state_next;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state <= cache_ctrl_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      cache_ctrl_pkg::ST_IDLE: begin
        if (req) begin
          state_next = cache_ctrl_pkg::ST_LOOKUP;
        end
      end
      cache_ctrl_pkg::ST_LOOKUP: begin
        if (hit) begin
          state_next = cache_ctrl_pkg::ST_IDLE;
        end else if (victim_dirty) begin
          state_next = cache_ctrl_pkg::ST_WRITEBACK;
        end else begin
          state_next = cache_ctrl_pkg::ST_REFILL;
        end
      end
      cache_ctrl_pkg::ST_WRITEBACK: begin
        state_next = cache_ctrl_pkg::ST_WAIT_WB;
      end
      cache_ctrl_pkg::ST_WAIT_WB: begin
        if (mem_ready) begin
          state_next = cache_ctrl_pkg::ST_REFILL;
        end
      end
      cache_ctrl_pkg::ST_REFILL: begin
        state_next = cache_ctrl_pkg::ST_WAIT_FILL;
      end
      cache_ctrl_pkg::ST_WAIT_FILL: begin
        // Back to lookup, which now hits
        if (mem_ready) begin
          state_next = cache_ctrl_pkg::ST_LOOKUP;
        end
      end
      default: begin
        state_next = cache_ctrl_pkg::ST_IDLE;
      end
    endcase
  end

  always_comb begin
    sample = 1'b0;
    set_valid = 1'b0;
    set_tag = 1'b0;
    fill = 1'b0;
    store = 1'b0;
    next_victim = 1'b0;
    wb_select = 1'b0;
    mem_rd_en = 1'b0;
    mem_wr_en = 1'b0;
    done = 1'b0;
    case (state)
      cache_ctrl_pkg::ST_IDLE: begin
        sample = req;
      end
      cache_ctrl_pkg::ST_LOOKUP: begin
        done = hit;
        store = hit & wr_en;
      end
      cache_ctrl_pkg::ST_WRITEBACK: begin
        wb_select = 1'b1;
        mem_wr_en = 1'b1;
      end
      cache_ctrl_pkg::ST_WAIT_WB: begin
        // Victim address held until memory answers
        wb_select = 1'b1;
      end
      cache_ctrl_pkg::ST_REFILL: begin
        mem_rd_en = 1'b1;
      end
      cache_ctrl_pkg::ST_WAIT_FILL: begin
        fill = mem_ready;
        set_tag = mem_ready;
        set_valid = mem_ready;
        next_victim = mem_ready;
      end
      default: begin
        done = 1'b0;
      end
    endcase
  end

endmodule

/* rtl/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

  localparam int STATE_W = 3;

  // Controller sequencing
  typedef enum logic [STATE_W-1:0] {
    ST_IDLE      = 3'd0,
    ST_LOOKUP    = 3'd1,
    ST_WRITEBACK = 3'd2,
    ST_WAIT_WB   = 3'd3,
    ST_REFILL    = 3'd4,
    ST_WAIT_FILL = 3'd5
  } cache_state_t;

endpackage

/* rtl/cache_geometry_pkg.sv */
package cache_geometry_pkg;

  // Processor side
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BYTE_W = 8;
  localparam int LANES = DATA_W / BYTE_W;
  localparam int LANE_W = $clog2(LANES);

  // Block layout
  localparam int BLOCK_W = 128;
  localparam int WORDS_W = $clog2(BLOCK_W / DATA_W);
  localparam int OFFSET_W = WORDS_W + LANE_W;

  // Associativity
  localparam int WAYS = 2;
  localparam int WAY_W = $clog2(WAYS);

  // 1 KiB total capacity
  localparam int CACHE_BYTES = 1024;
  localparam int SETS = CACHE_BYTES / (WAYS * (BLOCK_W / BYTE_W));
  localparam int INDEX_W = $clog2(SETS);

  // Whatever is left above index and offset
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  // Address fields, low bit of each
  localparam int WORD_LSB = LANE_W;
  localparam int INDEX_LSB = OFFSET_W;
  localparam int TAG_LSB = OFFSET_W + INDEX_W;

endpackage
